// ==== tb.f ====
src/vpu_num_pkg.sv
src/vpu_ctrl_pkg.sv
src/delay_line.sv
src/lane_dispatch.sv
src/pe_lane.sv
src/lane_collect.sv
src/vpu_top.sv
dv/vpu_top_sva.sv
dv/tb_vpu_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_vpu_top -f tb.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// ==== dv/tb_vpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// testbench for the vector unit that drives a beat table and checks reference results
module tb_vpu_top;

    import vpu_num_pkg::*;
    import vpu_ctrl_pkg::*;

    localparam int PIPE_LAT    = 1 + LANE_LAT + 1;  // input edge to o_y
    localparam int N_ROWS      = 28;
    localparam int N_DIRECTED  = 14;                // rows from here on are random
    localparam int TIMEOUT_CYC = N_ROWS * 20 + 100;

    typedef struct packed {
        op_e   op;
        word_t scalar;
        vec_t  a;
        vec_t  b;
        logic  valid_a;
        logic  valid_b;
        logic  last_a;
        logic  last_b;
    } beat_row_s;

    typedef struct packed {
        logic valid;
        logic last;
        vec_t y;
    } exp_s;

    logic      i_clk;
    logic      i_rst_n;
    logic      i_cmd_req;
    op_e       i_cmd_op;
    word_t     i_cmd_scalar;
    logic      o_cmd_ack;
    vec_t      i_a;
    vec_t      i_b;
    logic      i_valid_a;
    logic      i_valid_b;
    logic      i_last_a;
    logic      i_last_b;
    vec_t      o_y;
    logic      o_valid;
    logic      o_last;
    pkt_cnt_t  o_pkt_count;

    beat_row_s rows [N_ROWS];
    beat_row_s idle_row;    // both valids low
    exp_s      exp_q [$];   // one entry per driven cycle
    op_e       cur_op;      // op the dispatcher should hold
    word_t     cur_c;
    pkt_cnt_t  exp_cnt;
    int        cmd_phase;   // 0 idle, 1 req raised, 2 req dropped
    int        err_val;
    int        err_cmd;
    int        seed;
    int        cycle_cnt;

    vpu_top vpu_top_inst (.*);

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    // watchdog ends a run that stalls
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge i_clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        $display("TB FAILED");
        $finish;
    end

    // directed row with lanes spread out around a0 and b0
    task automatic put_row(input int idx, input op_e op, input word_t c,
                           input word_t a0, input word_t b0, input logic [3:0] flags);
        for (int i = 0; i < N_LANES; i++) begin
            rows[idx].a[i] = a0 + i * 32'h0001_0001;
            rows[idx].b[i] = b0 - i * 3;
        end
        rows[idx].op     = op;
        rows[idx].scalar = c;
        {rows[idx].valid_a, rows[idx].valid_b, rows[idx].last_a, rows[idx].last_b} = flags;
    endtask

    task automatic fill_random(input int idx);
        case ({$random(seed)} % 4)
            0:       rows[idx].op = ADD;
            1:       rows[idx].op = MUL;
            2:       rows[idx].op = MACC;
            default: rows[idx].op = NOP;
        endcase
        rows[idx].scalar = $random(seed);
        for (int i = 0; i < N_LANES; i++) begin
            rows[idx].a[i] = $random(seed);
            rows[idx].b[i] = $random(seed);
        end
        rows[idx].valid_a = ({$random(seed)} % 6) != 0;    // mostly valid
        rows[idx].valid_b = ({$random(seed)} % 6) != 0;
        rows[idx].last_a  = ({$random(seed)} % 4) == 0;
        rows[idx].last_b  = ({$random(seed)} % 4) == 0;
    endtask

    // reference result of one beat under a given op and scalar
    function automatic exp_s predict(input beat_row_s row, input op_e op, input word_t c);
        exp_s e;
        e.valid = row.valid_a && row.valid_b;
        e.last  = e.valid && (row.last_a || row.last_b);
        for (int i = 0; i < N_LANES; i++) begin
            case (op)
                ADD:     e.y[i] = row.a[i] + row.b[i];
                MUL:     e.y[i] = row.a[i] * row.b[i];        // low 32 bits
                MACC:    e.y[i] = row.a[i] * row.b[i] + c;
                default: e.y[i] = row.a[i];                   // NOP
            endcase
        end
        return e;
    endfunction

    task automatic check_out;
        exp_s e;
        if (exp_q.size() < PIPE_LAT) begin
            if (o_valid !== 1'b0) begin     // pipe still empty
                err_val++;
                $display("error o_valid expected %h got %h at %0t", 1'b0, o_valid, $time);
            end
        end else begin
            e = exp_q.pop_front();
            if (e.valid && e.last) exp_cnt++;
            if (o_valid !== e.valid) begin
                err_val++;
                $display("error o_valid expected %h got %h at %0t", e.valid, o_valid, $time);
            end
            if (o_last !== e.last) begin
                err_val++;
                $display("error o_last expected %h got %h at %0t", e.last, o_last, $time);
            end
            if (e.valid && o_y !== e.y) begin
                err_val++;
                $display("error o_y expected %h got %h at %0t", e.y, o_y, $time);
            end
            if (o_pkt_count !== exp_cnt) begin
                err_val++;
                $display("error o_pkt_count expected %h got %h at %0t",
                         exp_cnt, o_pkt_count, $time);
            end
        end
    endtask

    // host side of the four-phase command port
    task automatic service_cmd;
        case (cmd_phase)
            1: begin
                if (o_cmd_ack !== 1'b1) begin
                    err_cmd++;
                    $display("error o_cmd_ack expected %h got %h after req rose", 1'b1, o_cmd_ack);
                end
                i_cmd_req = 1'b0;
                cmd_phase = 2;
            end
            2: begin
                if (o_cmd_ack !== 1'b0) begin
                    err_cmd++;
                    $display("error o_cmd_ack expected %h got %h after req fell", 1'b0, o_cmd_ack);
                end
                cmd_phase = 0;
            end
            default: begin
                if (o_cmd_ack !== 1'b0) begin
                    err_cmd++;
                    $display("error o_cmd_ack expected %h got %h with no command",
                             1'b0, o_cmd_ack);
                end
            end
        endcase
    endtask

    task automatic tick;
        @(posedge i_clk);
        #2;     // outputs settled, inputs change here
        check_out();
        service_cmd();
    endtask

    task automatic start_cmd(input op_e op, input word_t c);
        i_cmd_op     = op;
        i_cmd_scalar = c;
        i_cmd_req    = 1'b1;
        cur_op       = op;  // the beat sent with req already takes it
        cur_c        = c;
        cmd_phase    = 1;
    endtask

    task automatic send(input beat_row_s row);
        i_a       = row.a;
        i_b       = row.b;
        i_valid_a = row.valid_a;
        i_valid_b = row.valid_b;
        i_last_a  = row.last_a;
        i_last_b  = row.last_b;
        exp_q.push_back(predict(row, cur_op, cur_c));
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_cmd_req    = 1'b0;
        i_cmd_op     = NOP;
        i_cmd_scalar = '0;
        i_a          = '0;
        i_b          = '0;
        i_valid_a    = 1'b0;
        i_valid_b    = 1'b0;
        i_last_a     = 1'b0;
        i_last_b     = 1'b0;
        cur_op       = NOP;     // reset state of the dispatcher
        cur_c        = '0;
        exp_cnt      = '0;
        cmd_phase    = 0;
        err_val      = 0;
        err_cmd      = 0;
        seed         = 32'h066094b0;
        idle_row     = '0;
        // flags are valid_a, valid_b, last_a, last_b
        put_row(0,  NOP,  0,            32'h0000_0010, 32'h0000_0100, 4'b1100);
        put_row(1,  NOP,  0,            32'h8000_0000, 1,             4'b1100);
        put_row(2,  NOP,  0,            32'h1234_5678, 7,             4'b1110);
        put_row(3,  ADD,  0,            32'h7fff_fffe, 5,             4'b1100);  // wraps
        put_row(4,  ADD,  0,            -3,            2,             4'b1000);  // bubble
        put_row(5,  ADD,  0,            32'hffff_ffff, 32'hffff_ffff, 4'b1101);
        put_row(6,  MUL,  0,            32'h0001_0003, 32'h0002_0007, 4'b1100);
        put_row(7,  MUL,  0,            -7,            12345,         4'b1100);
        put_row(8,  MUL,  0,            32'h4000_0000, 4,             4'b0110);  // last dropped
        put_row(9,  MACC, 32'h1234,     3,             4,             4'b1100);
        put_row(10, MACC, 32'h1234,     -5,            6,             4'b1110);
        put_row(11, MACC, 32'h8000_0000, 32'h7fff_ffff, 2,            4'b1100);
        put_row(12, ADD,  32'h10,       100,           200,           4'b1100);
        put_row(13, NOP,  32'h10,       99,            0,             4'b1101);
        for (int r = N_DIRECTED; r < N_ROWS; r++) begin
            fill_random(r);
        end

        repeat (3) @(posedge i_clk);
        #2;
        i_rst_n = 1'b1;
        if (o_valid !== 1'b0) begin
            err_val++;
            $display("error o_valid expected %h got %h after reset", 1'b0, o_valid);
        end
        if (o_last !== 1'b0) begin
            err_val++;
            $display("error o_last expected %h got %h after reset", 1'b0, o_last);
        end
        if (o_cmd_ack !== 1'b0) begin
            err_cmd++;
            $display("error o_cmd_ack expected %h got %h after reset", 1'b0, o_cmd_ack);
        end
        if (o_pkt_count !== '0) begin
            err_val++;
            $display("error o_pkt_count expected %h got %h after reset", 16'h0, o_pkt_count);
        end

        for (int r = 0; r < N_ROWS; r++) begin
            if (rows[r].op != cur_op || rows[r].scalar != cur_c) begin
                while (cmd_phase != 0) begin    // last handshake still closing
                    send(idle_row);
                    tick();
                end
                start_cmd(rows[r].op, rows[r].scalar);
            end
            send(rows[r]);
            tick();
        end
        repeat (PIPE_LAT) begin     // drain the pipe
            send(idle_row);
            tick();
        end

        $display("checks done: %0d datapath errors, %0d command port errors", err_val, err_cmd);
        if (err_val + err_cmd == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/vpu_top_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the command port and the output stream
module vpu_top_sva (
    input wire logic i_clk,
    input wire logic i_rst_n,
    input wire logic i_cmd_req,
    input wire logic i_cmd_ack,
    input wire logic i_valid,
    input wire logic i_last
);

    // ack goes up only in answer to req
    ack_rise_chk: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_cmd_ack) |-> $past(i_cmd_req))
        else $error("o_cmd_ack rose while i_cmd_req was low");

    ack_fall_chk: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_cmd_ack) |-> !$past(i_cmd_req))    // req dropped first
        else $error("o_cmd_ack fell while i_cmd_req was still high");

    rst_valid_chk: assert property (@(posedge i_clk) !i_rst_n |=> !i_valid)
        else $error("o_valid high after a reset cycle");

    last_valid_chk: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_last |-> i_valid)
        else $error("o_last high without o_valid");

endmodule

bind vpu_top vpu_top_sva vpu_top_sva_inst (
    .i_clk     (i_clk),
    .i_rst_n   (i_rst_n),
    .i_cmd_req (i_cmd_req),
    .i_cmd_ack (o_cmd_ack),
    .i_valid   (o_valid),
    .i_last    (o_last)
);

`default_nettype wire

// ==== src/vpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// vector unit built from a dispatcher, N_LANES elements and a collector
module vpu_top (
    input  wire logic               i_clk,
    input  wire logic               i_rst_n,
    input  wire logic               i_cmd_req,
    input  wire vpu_ctrl_pkg::op_e  i_cmd_op,
    input  wire vpu_num_pkg::word_t i_cmd_scalar,
    output logic                    o_cmd_ack,
    input  wire vpu_num_pkg::vec_t  i_a,
    input  wire vpu_num_pkg::vec_t  i_b,
    input  wire logic               i_valid_a,
    input  wire logic               i_valid_b,
    input  wire logic               i_last_a,
    input  wire logic               i_last_b,
    output vpu_num_pkg::vec_t       o_y,
    output logic                    o_valid,
    output logic                    o_last,
    output vpu_num_pkg::pkt_cnt_t   o_pkt_count
);

    import vpu_num_pkg::*;
    import vpu_ctrl_pkg::*;

    lane_in_s  lane_in  [N_LANES];
    lane_out_s lane_out [N_LANES];

    lane_dispatch lane_dispatch_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cmd_req    (i_cmd_req),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_scalar (i_cmd_scalar),
        .o_cmd_ack    (o_cmd_ack),
        .i_a          (i_a),
        .i_b          (i_b),
        .i_valid_a    (i_valid_a),
        .i_valid_b    (i_valid_b),
        .i_last_a     (i_last_a),
        .i_last_b     (i_last_b),
        .o_lane_in    (lane_in)
    );

    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        pe_lane pe_lane_inst (
            .i_clk   (i_clk),
            .i_rst_n (i_rst_n),
            .i_in    (lane_in[g]),
            .o_out   (lane_out[g])
        );
    end

    lane_collect lane_collect_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_lane_out  (lane_out),
        .o_y         (o_y),
        .o_valid     (o_valid),
        .o_last      (o_last),
        .o_pkt_count (o_pkt_count)
    );

endmodule

`default_nettype wire

// ==== src/lane_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

// packs lane results back into one vector and counts packets
module lane_collect (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire vpu_ctrl_pkg::lane_out_s i_lane_out [vpu_num_pkg::N_LANES],
    output vpu_num_pkg::vec_t            o_y,
    output logic                         o_valid,
    output logic                         o_last,
    output vpu_num_pkg::pkt_cnt_t        o_pkt_count
);

    import vpu_num_pkg::*;

    logic beat_end;     // lane 0 shows a last beat

    // lanes move in lockstep so lane 0 speaks for all
    assign beat_end = i_lane_out[0].valid && i_lane_out[0].last;

    always_ff @(posedge i_clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            o_y[i] <= i_lane_out[i].y;      // lane i to word i
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid     <= 1'b0;
            o_last      <= 1'b0;
            o_pkt_count <= '0;
        end else begin
            o_valid <= i_lane_out[0].valid;
            o_last  <= beat_end;
            if (beat_end) o_pkt_count <= o_pkt_count + 1'b1;     // moves with o_last
        end
    end

endmodule

`default_nettype wire

// ==== src/pe_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

// one processing element with a multiply half followed by an add half
module pe_lane (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire vpu_ctrl_pkg::lane_in_s i_in,
    output vpu_ctrl_pkg::lane_out_s     o_out
);

    import vpu_num_pkg::*;
    import vpu_ctrl_pkg::*;

    word_t     prod;            // low word of a*b
    logic      mul_v;           // product valid, MUL and MACC only
    word_t     prod_d;          // product after MUL_LAT
    logic      mul_v_d;
    lane_in_s  in_d;            // whole beat after MUL_LAT

    word_t     add_a;
    word_t     add_b;
    word_t     sum;
    logic      add_v;
    lane_out_s add_in;          // adder result entering the add half
    lane_out_s mul_in;          // MUL result waiting out the add half
    lane_out_s nop_in;          // a passed through for NOP
    lane_out_s add_out;
    lane_out_s mul_out;
    lane_out_s nop_out;

    logic [$bits(op_e)-1:0] op_dd_bits;
    op_e                    op_dd;      // op delayed by LANE_LAT

    // multiply half
    assign prod  = i_in.a * i_in.b;     // wraps to 32 bits
    assign mul_v = i_in.valid && (i_in.op == MUL || i_in.op == MACC);

    delay_line #(.WIDTH(WORD_W + 1), .DEPTH(MUL_LAT)) mul_pipe_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     ({mul_v, prod}),
        .o_q     ({mul_v_d, prod_d})
    );

    delay_line #(.WIDTH($bits(lane_in_s)), .DEPTH(MUL_LAT)) in_pipe_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (i_in),
        .o_q     (in_d)     // a, b, c, op, valid, last alongside the product
    );

    // add half takes a+b for ADD and a*b+c for MACC
    assign add_a = (in_d.op == ADD) ? in_d.a : prod_d;
    assign add_b = (in_d.op == ADD) ? in_d.b : in_d.c;
    assign sum   = add_a + add_b;
    assign add_v = (in_d.op == ADD)  ? in_d.valid :
                   (in_d.op == MACC) ? mul_v_d    : 1'b0;

    assign add_in = '{valid: add_v,   last: in_d.last, y: sum};
    assign mul_in = '{valid: mul_v_d, last: in_d.last, y: prod_d};
    assign nop_in = '{valid: in_d.valid, last: in_d.last, y: in_d.a};

    delay_line #(.WIDTH($bits(lane_out_s)), .DEPTH(ADD_LAT)) add_pipe_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (add_in),
        .o_q     (add_out)
    );

    delay_line #(.WIDTH($bits(lane_out_s)), .DEPTH(ADD_LAT)) mul_hold_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (mul_in),
        .o_q     (mul_out)
    );

    delay_line #(.WIDTH($bits(lane_out_s)), .DEPTH(ADD_LAT)) nop_hold_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (nop_in),
        .o_q     (nop_out)
    );

    delay_line #(.WIDTH($bits(op_e)), .DEPTH(ADD_LAT)) op_pipe_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_d     (in_d.op),
        .o_q     (op_dd_bits)
    );

    assign op_dd = op_e'(op_dd_bits);

    // every path is LANE_LAT deep, so the select just follows the op
    always_comb begin
        case (op_dd)
            ADD:     o_out = add_out;
            MACC:    o_out = add_out;
            MUL:     o_out = mul_out;
            NOP:     o_out = nop_out;
            default: o_out = '0;        // unused code gives no beat
        endcase
    end

endmodule

`default_nettype wire

// ==== src/lane_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

// command port, op/scalar registers and per-lane beat register
module lane_dispatch (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    // four-phase command port
    input  wire logic                   i_cmd_req,
    input  wire vpu_ctrl_pkg::op_e      i_cmd_op,
    input  wire vpu_num_pkg::word_t     i_cmd_scalar,
    output logic                        o_cmd_ack,
    // operand streams
    input  wire vpu_num_pkg::vec_t      i_a,
    input  wire vpu_num_pkg::vec_t      i_b,
    input  wire logic                   i_valid_a,
    input  wire logic                   i_valid_b,
    input  wire logic                   i_last_a,
    input  wire logic                   i_last_b,
    // one registered beat per lane
    output vpu_ctrl_pkg::lane_in_s      o_lane_in [vpu_num_pkg::N_LANES]
);

    import vpu_num_pkg::*;
    import vpu_ctrl_pkg::*;

    typedef enum logic {
        IDLE,   // waiting for req
        ACKED   // ack high, waiting for req to drop
    } cmd_state_e;

    cmd_state_e state_q;
    op_e        op_q;       // current op, NOP after reset
    word_t      scalar_q;   // current scalar c
    logic       cmd_take;   // req seen while ack low
    op_e        beat_op;
    word_t      beat_c;
    logic       beat_ok;
    logic       beat_last;

    assign cmd_take  = (state_q == IDLE) && i_cmd_req;
    assign o_cmd_ack = (state_q == ACKED);

    // a beat on the latching edge already gets the new command
    assign beat_op   = cmd_take ? i_cmd_op : op_q;
    assign beat_c    = cmd_take ? i_cmd_scalar : scalar_q;

    assign beat_ok   = i_valid_a && i_valid_b;              // one valid low is a bubble
    assign beat_last = beat_ok && (i_last_a || i_last_b);   // last of either stream

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q  <= IDLE;
            op_q     <= NOP;
            scalar_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (i_cmd_req) begin
                        state_q  <= ACKED;
                        op_q     <= i_cmd_op;       // host holds these steady with req
                        scalar_q <= i_cmd_scalar;
                    end
                end
                ACKED: begin
                    if (!i_cmd_req) state_q <= IDLE;    // ack drops next cycle
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // slice the vectors, tag each lane with op and scalar
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            o_lane_in[i].op <= beat_op;
            o_lane_in[i].a  <= i_a[i];
            o_lane_in[i].b  <= i_b[i];
            o_lane_in[i].c  <= beat_c;
            if (!i_rst_n) begin
                o_lane_in[i].valid <= 1'b0;
                o_lane_in[i].last  <= 1'b0;
            end else begin
                o_lane_in[i].valid <= beat_ok;
                o_lane_in[i].last  <= beat_last;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/delay_line.sv ====
`timescale 1ns/1ps
`default_nettype none

// plain shift register with DEPTH stages of WIDTH bits
module delay_line #(
    parameter int WIDTH = 1,
    parameter int DEPTH = 1     // must be 1 or more
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic [WIDTH-1:0] i_d,
    output logic      [WIDTH-1:0] o_q
);

    logic [DEPTH-1:0][WIDTH-1:0] pipe_q;    // stage 0 is the input side

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pipe_q <= '0;   // valid and last bits come out low
        end else begin
            pipe_q[0] <= i_d;
            for (int i = 1; i < DEPTH; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign o_q = pipe_q[DEPTH-1];

endmodule

`default_nettype wire

// ==== src/vpu_ctrl_pkg.sv ====
`default_nettype none

// op encoding, pipeline depths and the per-lane beat records
package vpu_ctrl_pkg;

    // 3'b001 is left free for an accumulate op
    typedef enum logic [2:0] {
        ADD  = 3'b000,
        MUL  = 3'b010,
        MACC = 3'b011,
        NOP  = 3'b100
    } op_e;

    localparam int MUL_LAT  = 4;                    // multiply half depth
    localparam int ADD_LAT  = 4;                    // add half depth
    localparam int LANE_LAT = MUL_LAT + ADD_LAT;    // entry to result, every op

    // one beat entering a lane
    typedef struct packed {
        logic               valid;
        logic               last;   // already gated by valid
        op_e                op;     // op travels with the beat
        vpu_num_pkg::word_t a;
        vpu_num_pkg::word_t b;
        vpu_num_pkg::word_t c;      // broadcast scalar
    } lane_in_s;

    // one beat leaving a lane
    typedef struct packed {
        logic               valid;
        logic               last;
        vpu_num_pkg::word_t y;
    } lane_out_s;

endpackage

`default_nettype wire

// ==== src/vpu_num_pkg.sv ====
`default_nettype none

// numeric types shared by every block of the vector unit
package vpu_num_pkg;

    localparam int N_LANES = 4;     // lanes working side by side
    localparam int WORD_W  = 32;    // one two's complement operand
    localparam int PKT_W   = 16;    // packet counter width

    // one signed operand or lane result that wraps on overflow
    typedef logic signed [WORD_W-1:0] word_t;

    // a whole vector with lane 0 in the low word
    typedef word_t [N_LANES-1:0] vec_t;

    typedef logic [PKT_W-1:0] pkt_cnt_t;    // counts beats that carried last

endpackage

`default_nettype wire
